/* hw/sim_mem_pkg.sv */
package sim_mem_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned IdWidth     = 4;
  localparam int unsigned LenWidth    = 8;
  localparam int unsigned SizeWidth   = 3;
  localparam int unsigned MemWords    = 1024;
  localparam int unsigned MemIdxWidth = $clog2(MemWords);

  // Address map, both alias into the memory
  localparam logic [AddrWidth-1:0] UartAddr = 32'hC000_0000;
  localparam logic [AddrWidth-1:0] EocAddr  = 32'hD000_0000;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [StrbWidth-1:0]   strb_t;
  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [LenWidth-1:0]    len_t;
  typedef logic [SizeWidth-1:0]   size_t;
  typedef logic [MemIdxWidth-1:0] mem_idx_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // Next beat address, every burst type stepped as INCR
  function automatic addr_t step_addr(addr_t addr, size_t size);
    return ((addr >> size) + addr_t'(1)) << size;
  endfunction

  function automatic mem_idx_t word_idx(addr_t addr);
    return addr[MemIdxWidth+2:3];
  endfunction

endpackage

/* hw/mem_write_if.sv */
`timescale 1ns/100ps

interface mem_write_if;
  import sim_mem_pkg::*;

  // One strobe per accepted W beat, memory always accepts
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;
  strb_t wr_strb;

  modport source (output wr_en, wr_addr, wr_data, wr_strb);
  modport sink (input wr_en, wr_addr, wr_data, wr_strb);
  modport monitor (input wr_en, wr_addr, wr_data, wr_strb);

endinterface

/* hw/sim_mem_array.sv */
`timescale 1ns/100ps

module sim_mem_array (
  input  logic               clk,
  mem_write_if.sink          mem_w,
  input  logic               rd_en_i,
  input  sim_mem_pkg::addr_t rd_addr_i,
  output sim_mem_pkg::data_t rd_data_o
);
  import sim_mem_pkg::*;

  data_t    mem_q [MemWords];
  mem_idx_t wr_idx;
  mem_idx_t rd_idx;

  assign wr_idx = word_idx(mem_w.wr_addr);
  assign rd_idx = word_idx(rd_addr_i);

  // Byte lanes written only where strobed
  always_ff @(posedge clk) begin
    if (mem_w.wr_en) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (mem_w.wr_strb[b]) begin
          mem_q[wr_idx][b*8 +: 8] <= mem_w.wr_data[b*8 +: 8];
        end
      end
    end
  end

  // Holds the last fetched word until the next fetch
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_idx];
    end
  end

endmodule

/* hw/axi_write_engine.sv */
`timescale 1ns/100ps

module axi_write_engine (
  input  logic                    clk,
  input  logic                    rst_i,
  input  sim_mem_pkg::id_t        aw_id_i,
  input  sim_mem_pkg::addr_t      aw_addr_i,
  input  sim_mem_pkg::len_t       aw_len_i,
  input  sim_mem_pkg::size_t      aw_size_i,
  input  sim_mem_pkg::axi_burst_e aw_burst_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  sim_mem_pkg::data_t      w_data_i,
  input  sim_mem_pkg::strb_t      w_strb_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output sim_mem_pkg::id_t        b_id_o,
  output sim_mem_pkg::axi_resp_e  b_resp_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  mem_write_if.source             mem_w
);
  import sim_mem_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e state_q;
  len_t      beats_q;
  id_t       id_q;
  addr_t     addr_q;
  size_t     size_q;
  logic      aw_fire;
  logic      w_fire;

  assign aw_ready_o = (state_q == WR_IDLE);
  assign w_ready_o  = (state_q == WR_DATA);
  assign b_valid_o  = (state_q == WR_RESP);
  assign b_id_o     = id_q;
  assign b_resp_o   = RESP_OKAY;

  // aw_burst_i is accepted as is, stepping is always INCR
  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire  = w_valid_i && w_ready_o;

  assign mem_w.wr_en   = w_fire;
  assign mem_w.wr_addr = addr_q;
  assign mem_w.wr_data = w_data_i;
  assign mem_w.wr_strb = w_strb_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= WR_IDLE;
      beats_q <= '0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            state_q <= WR_DATA;
            beats_q <= aw_len_i;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            // Burst ends on the beat count, not on w_last
            if (beats_q == '0) begin
              state_q <= WR_RESP;
            end else begin
              beats_q <= beats_q - len_t'(1);
            end
          end
        end
        WR_RESP: begin
          if (b_ready_i) begin
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= aw_id_i;
      addr_q <= aw_addr_i;
      size_q <= aw_size_i;
    end else if (w_fire) begin
      addr_q <= step_addr(addr_q, size_q);
    end
  end

endmodule

/* hw/axi_read_engine.sv */
`timescale 1ns/100ps

module axi_read_engine (
  input  logic                    clk,
  input  logic                    rst_i,
  input  sim_mem_pkg::id_t        ar_id_i,
  input  sim_mem_pkg::addr_t      ar_addr_i,
  input  sim_mem_pkg::len_t       ar_len_i,
  input  sim_mem_pkg::size_t      ar_size_i,
  input  sim_mem_pkg::axi_burst_e ar_burst_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output sim_mem_pkg::id_t        r_id_o,
  output sim_mem_pkg::data_t      r_data_o,
  output sim_mem_pkg::axi_resp_e  r_resp_o,
  output logic                    r_last_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output logic                    rd_en_o,
  output sim_mem_pkg::addr_t      rd_addr_o,
  input  sim_mem_pkg::data_t      rd_data_i
);
  import sim_mem_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_SEND
  } rd_state_e;

  rd_state_e state_q;
  len_t      beats_q;
  id_t       id_q;
  addr_t     addr_q;
  size_t     size_q;
  logic      ar_fire;
  logic      r_fire;

  // ar_burst_i is accepted as is, stepping is always INCR
  assign ar_fire = ar_valid_i && ar_ready_o;
  assign r_fire  = r_valid_o && r_ready_i;

  assign ar_ready_o = (state_q == RD_IDLE);
  assign rd_en_o    = (state_q == RD_FETCH);
  assign rd_addr_o  = addr_q;

  // Memory output register holds the word while R stalls
  assign r_valid_o = (state_q == RD_SEND);
  assign r_data_o  = rd_data_i;
  assign r_id_o    = id_q;
  assign r_resp_o  = RESP_OKAY;
  assign r_last_o  = r_valid_o && (beats_q == '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= RD_IDLE;
      beats_q <= '0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (ar_fire) begin
            state_q <= RD_FETCH;
            beats_q <= ar_len_i;
          end
        end
        RD_FETCH: state_q <= RD_SEND;
        RD_SEND: begin
          if (r_fire) begin
            if (beats_q == '0) begin
              state_q <= RD_IDLE;
            end else begin
              state_q <= RD_FETCH;
              beats_q <= beats_q - len_t'(1);
            end
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= ar_id_i;
      addr_q <= ar_addr_i;
      size_q <= ar_size_i;
    end else if (r_fire) begin
      addr_q <= step_addr(addr_q, size_q);
    end
  end

endmodule

/* hw/mmio_sink.sv */
`timescale 1ns/100ps

module mmio_sink (
  input  logic        clk,
  input  logic        rst_i,
  mem_write_if.monitor mem_w,
  output logic        uart_valid_o,
  output logic [7:0]  uart_char_o,
  output logic        eoc_o
);
  import sim_mem_pkg::*;

  logic uart_hit;
  logic eoc_hit;

  // Console takes the low byte only
  assign uart_hit = mem_w.wr_en && (mem_w.wr_addr == UartAddr) && mem_w.wr_strb[0];
  assign eoc_hit  = mem_w.wr_en && (mem_w.wr_addr == EocAddr);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      uart_valid_o <= 1'b0;
      uart_char_o  <= '0;
      eoc_o        <= 1'b0;
    end else begin
      uart_valid_o <= uart_hit;
      if (uart_hit) begin
        uart_char_o <= mem_w.wr_data[7:0];
      end
      // Sticky until reset
      eoc_o <= eoc_o || eoc_hit;
    end
  end

endmodule

/* hw/sim_mem_top.sv */
`timescale 1ns/100ps

module sim_mem_top (
  input  logic                    clk,
  input  logic                    rst_i,
  input  sim_mem_pkg::id_t        aw_id_i,
  input  sim_mem_pkg::addr_t      aw_addr_i,
  input  sim_mem_pkg::len_t       aw_len_i,
  input  sim_mem_pkg::size_t      aw_size_i,
  input  sim_mem_pkg::axi_burst_e aw_burst_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  sim_mem_pkg::data_t      w_data_i,
  input  sim_mem_pkg::strb_t      w_strb_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output sim_mem_pkg::id_t        b_id_o,
  output sim_mem_pkg::axi_resp_e  b_resp_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  input  sim_mem_pkg::id_t        ar_id_i,
  input  sim_mem_pkg::addr_t      ar_addr_i,
  input  sim_mem_pkg::len_t       ar_len_i,
  input  sim_mem_pkg::size_t      ar_size_i,
  input  sim_mem_pkg::axi_burst_e ar_burst_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output sim_mem_pkg::id_t        r_id_o,
  output sim_mem_pkg::data_t      r_data_o,
  output sim_mem_pkg::axi_resp_e  r_resp_o,
  output logic                    r_last_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output logic                    uart_valid_o,
  output logic [7:0]              uart_char_o,
  output logic                    eoc_o
);
  import sim_mem_pkg::*;

  logic  rd_en;
  addr_t rd_addr;
  data_t rd_data;

  mem_write_if mem_w ();

  axi_write_engine axi_write_engine_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .aw_len_i   (aw_len_i),
    .aw_size_i  (aw_size_i),
    .aw_burst_i (aw_burst_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .mem_w      (mem_w)
  );

  axi_read_engine axi_read_engine_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .ar_len_i   (ar_len_i),
    .ar_size_i  (ar_size_i),
    .ar_burst_i (ar_burst_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_id_o     (r_id_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .rd_en_o    (rd_en),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data)
  );

  sim_mem_array sim_mem_array_i (
    .clk       (clk),
    .mem_w     (mem_w),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  mmio_sink mmio_sink_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .mem_w        (mem_w),
    .uart_valid_o (uart_valid_o),
    .uart_char_o  (uart_char_o),
    .eoc_o        (eoc_o)
  );

endmodule

/* verification/tb_sim_mem.sv */
`timescale 1ns/100ps

module tb_sim_mem;
  import sim_mem_pkg::*;

  localparam int Timeout = 500;

  logic       clk;
  logic       rst_i;
  id_t        aw_id_i;
  addr_t      aw_addr_i;
  len_t       aw_len_i;
  size_t      aw_size_i;
  axi_burst_e aw_burst_i;
  logic       aw_valid_i;
  logic       aw_ready_o;
  data_t      w_data_i;
  strb_t      w_strb_i;
  logic       w_valid_i;
  logic       w_ready_o;
  id_t        b_id_o;
  axi_resp_e  b_resp_o;
  logic       b_valid_o;
  logic       b_ready_i;
  id_t        ar_id_i;
  addr_t      ar_addr_i;
  len_t       ar_len_i;
  size_t      ar_size_i;
  axi_burst_e ar_burst_i;
  logic       ar_valid_i;
  logic       ar_ready_o;
  id_t        r_id_o;
  data_t      r_data_o;
  axi_resp_e  r_resp_o;
  logic       r_last_o;
  logic       r_valid_o;
  logic       r_ready_i;
  logic       uart_valid_o;
  logic [7:0] uart_char_o;
  logic       eoc_o;

  logic [31:0] lfsr = 32'hd61f4140;
  data_t       ref_mem [MemWords];
  data_t       wr_data_q [$];
  strb_t       wr_strb_q [$];
  data_t       exp_data_q [$];
  logic        exp_last_q [$];
  id_t         exp_rid;
  logic        r_held = 1'b0;
  data_t       held_data;
  logic        held_last;
  int          uart_pulses = 0;
  int          errors = 0;
  int          mark = 0;
  int          tests = 0;
  int          failed = 0;

  sim_mem_top sim_mem_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[DataWidth-2:0], lfsr[0]};
    end
    return v;
  endfunction

  // Start of the next beat after aligning down to the beat size
  function automatic addr_t next_addr(input addr_t a, input size_t size);
    addr_t bytes;
    bytes = addr_t'(1) << size;
    return (a & ~(bytes - addr_t'(1))) + bytes;
  endfunction

  // Expected word for one beat of a burst
  function automatic data_t ref_word(input addr_t start, input size_t size, input int beat);
    addr_t a;
    a = start;
    for (int i = 0; i < beat; i++) begin
      a = next_addr(a, size);
    end
    return ref_mem[mem_idx_t'(a >> 3)];
  endfunction

  task automatic ref_write(input addr_t a, input data_t d, input strb_t s);
    for (int b = 0; b < StrbWidth; b++) begin
      if (s[b]) begin
        ref_mem[mem_idx_t'(a >> 3)][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic signal_level(input string name);
    if (name == "aw_ready_o") return aw_ready_o;
    if (name == "w_ready_o") return w_ready_o;
    if (name == "b_valid_o") return b_valid_o;
    if (name == "ar_ready_o") return ar_ready_o;
    return r_valid_o;
  endfunction

  task automatic wait_signal(input string name, output int cycles);
    cycles = 0;
    while (!signal_level(name) && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!signal_level(name)) begin
      $display("Timeout at %0t: %s never went high", $time, name);
      errors++;
    end
  endtask

  // Sends the queued beats as one burst, then takes the B response
  task automatic axi_write(input addr_t addr, input size_t size, input id_t id, input bit bp);
    addr_t a;
    int    n;
    int    gap;
    logic  uart_hit;
    a = addr;
    aw_id_i = id;
    aw_addr_i = addr;
    aw_len_i = len_t'(wr_data_q.size() - 1);
    aw_size_i = size;
    aw_valid_i = 1'b1;
    wait_signal("aw_ready_o", n);
    @(negedge clk);
    aw_valid_i = 1'b0;
    for (int i = 0; i < wr_data_q.size(); i++) begin
      gap = bp ? int'(rand_bits(2)) : 0;
      repeat (gap) @(negedge clk);
      w_data_i = wr_data_q[i];
      w_strb_i = wr_strb_q[i];
      w_valid_i = 1'b1;
      wait_signal("w_ready_o", n);
      ref_write(a, w_data_i, w_strb_i);
      @(negedge clk);
      w_valid_i = 1'b0;
      // Side effects show one cycle after the beat
      uart_hit = (a == UartAddr) && wr_strb_q[i][0];
      check_bit("uart_valid_o", uart_valid_o, uart_hit);
      if (uart_hit) begin
        check_data("uart_char_o", data_t'(uart_char_o), data_t'(wr_data_q[i][7:0]));
      end
      if (a == EocAddr) begin
        check_bit("eoc_o", eoc_o, 1'b1);
      end
      a = next_addr(a, size);
    end
    gap = bp ? int'(rand_bits(3)) : 0;
    repeat (gap) begin
      @(negedge clk);
      check_bit("aw_ready_o", aw_ready_o, 1'b0);
    end
    b_ready_i = 1'b1;
    wait_signal("b_valid_o", n);
    check_id("b_id_o", b_id_o, id);
    check_resp("b_resp_o", b_resp_o, RESP_OKAY);
    @(negedge clk);
    b_ready_i = 1'b0;
    wr_data_q.delete();
    wr_strb_q.delete();
  endtask

  task automatic axi_read(input addr_t addr, input len_t len, input size_t size, input id_t id,
                          input bit bp);
    int   n;
    logic done;
    for (int i = 0; i <= int'(len); i++) begin
      exp_data_q.push_back(ref_word(addr, size, i));
      exp_last_q.push_back(i == int'(len));
    end
    exp_rid = id;
    ar_id_i = id;
    ar_addr_i = addr;
    ar_len_i = len;
    ar_size_i = size;
    ar_valid_i = 1'b1;
    wait_signal("ar_ready_o", n);
    @(negedge clk);
    ar_valid_i = 1'b0;
    wait_signal("r_valid_o", n);
    if (n != 1) begin
      $display("** Error at %0t: r_valid_o delay = %0d, expected 2", $time, n + 1);
      errors++;
    end
    done = 1'b0;
    n = 0;
    while (!done && n < Timeout) begin
      r_ready_i = !bp || (rand_bits(2) == '0);
      done = r_valid_o && r_ready_i && r_last_o;
      @(negedge clk);
      n++;
    end
    r_ready_i = 1'b0;
    if (exp_data_q.size() != 0) begin
      $display("R burst incomplete at %0t, %0d beats missing", $time, exp_data_q.size());
      errors++;
      exp_data_q.delete();
      exp_last_q.delete();
    end
  endtask

  task automatic burst_pair(input size_t size, input bit bp);
    addr_t base;
    addr_t a;
    len_t  len;
    base = (size == 3'd3) ? (addr_t'(rand_bits(5)) << 3) : (addr_t'(rand_bits(6)) << 2);
    len = len_t'(rand_bits(4));
    a = base;
    for (int i = 0; i <= int'(len); i++) begin
      wr_data_q.push_back(rand_bits(64));
      // Half-word lanes at size 2
      if (size == 3'd3) begin
        wr_strb_q.push_back(8'hFF);
      end else begin
        wr_strb_q.push_back(a[2] ? 8'hF0 : 8'h0F);
      end
      a = next_addr(a, size);
    end
    axi_write(base, size, id_t'(rand_bits(4)), bp);
    axi_read(base, len, size, id_t'(rand_bits(4)), bp);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors != mark) begin
      failed++;
    end
    $display("test %-14s %s", name, (errors == mark) ? "ok" : "FAILED");
    mark = errors;
  endtask

  // R channel compare at the rising edge
  always @(posedge clk) begin
    if (!rst_i && uart_valid_o) begin
      uart_pulses++;
    end
    if (!rst_i && r_held) begin
      check_bit("r_valid_o (held)", r_valid_o, 1'b1);
      check_data("r_data_o (held)", r_data_o, held_data);
      check_bit("r_last_o (held)", r_last_o, held_last);
      r_held = 1'b0;
    end
    if (!rst_i && r_valid_o) begin
      if (r_ready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("Unexpected R beat at %0t with no read outstanding", $time);
          errors++;
        end else begin
          check_data("r_data_o", r_data_o, exp_data_q.pop_front());
          check_bit("r_last_o", r_last_o, exp_last_q.pop_front());
          check_id("r_id_o", r_id_o, exp_rid);
          check_resp("r_resp_o", r_resp_o, RESP_OKAY);
        end
      end else begin
        r_held = 1'b1;
        held_data = r_data_o;
        held_last = r_last_o;
      end
    end
  end

  initial begin
    #4_000_000;
    $display("Simulation time limit reached");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    data_t d;
    addr_t a;
    id_t   id;
    int    p0;
    string msg;
    rst_i = 1'b1;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    aw_size_i = '0;
    aw_burst_i = BURST_INCR;
    aw_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_valid_i = 1'b0;
    b_ready_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_size_i = '0;
    ar_burst_i = BURST_INCR;
    ar_valid_i = 1'b0;
    r_ready_i = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      ref_mem[i] = '0;
    end
    repeat (3) @(negedge clk);
    rst_i = 1'b0;

    check_bit("aw_ready_o", aw_ready_o, 1'b1);
    check_bit("ar_ready_o", ar_ready_o, 1'b1);
    check_bit("w_ready_o", w_ready_o, 1'b0);
    check_bit("b_valid_o", b_valid_o, 1'b0);
    check_bit("r_valid_o", r_valid_o, 1'b0);
    check_bit("uart_valid_o", uart_valid_o, 1'b0);
    check_bit("eoc_o", eoc_o, 1'b0);
    id = id_t'(rand_bits(4));
    wr_data_q.push_back(rand_bits(64));
    wr_strb_q.push_back(8'hFF);
    axi_write(32'h40, 3'd3, id, 1'b0);
    axi_read(32'h40, 8'd0, 3'd3, id, 1'b0);
    finish_test("reset_single");

    // Known contents before the merged bytes
    for (int i = 0; i < 64; i++) begin
      wr_data_q.push_back(rand_bits(64));
      wr_strb_q.push_back(8'hFF);
    end
    axi_write(32'h0, 3'd3, 4'd1, 1'b0);
    repeat (8) begin
      a = addr_t'(rand_bits(6)) << 3;
      wr_data_q.push_back(rand_bits(64));
      wr_strb_q.push_back(strb_t'(rand_bits(8)));
      axi_write(a, 3'd3, id_t'(rand_bits(4)), 1'b0);
      axi_read(a, 8'd0, 3'd3, id_t'(rand_bits(4)), 1'b0);
    end
    finish_test("strobes");

    repeat (4) burst_pair(3'd3, 1'b0);
    repeat (4) burst_pair(3'd2, 1'b0);
    finish_test("bursts");

    repeat (3) begin
      burst_pair(3'd3, 1'b1);
      burst_pair(3'd2, 1'b1);
    end
    finish_test("backpressure");

    msg = "sim_mem ok";
    p0 = uart_pulses;
    for (int i = 0; i < msg.len(); i++) begin
      d = rand_bits(64);
      d[7:0] = msg[i];
      wr_data_q.push_back(d);
      wr_strb_q.push_back(strb_t'(rand_bits(8)) | 8'h01);
      axi_write(UartAddr, 3'd3, id_t'(rand_bits(4)), 1'b0);
    end
    // Low lane not strobed so no character appears
    wr_data_q.push_back(rand_bits(64));
    wr_strb_q.push_back(8'hFE);
    axi_write(UartAddr, 3'd3, id_t'(rand_bits(4)), 1'b0);
    repeat (3) @(negedge clk);
    if (uart_pulses - p0 != msg.len()) begin
      $display("** Error at %0t: uart_valid_o pulses = %0d, expected %0d",
               $time, uart_pulses - p0, msg.len());
      errors++;
    end
    finish_test("console");

    check_bit("eoc_o", eoc_o, 1'b0);
    wr_data_q.push_back(rand_bits(64));
    wr_strb_q.push_back(8'hFF);
    axi_write(EocAddr, 3'd3, id_t'(rand_bits(4)), 1'b0);
    burst_pair(3'd3, 1'b1);
    axi_read(EocAddr, 8'd0, 3'd3, id_t'(rand_bits(4)), 1'b0);
    check_bit("eoc_o", eoc_o, 1'b1);
    finish_test("eoc");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
hw/sim_mem_pkg.sv
hw/mem_write_if.sv
hw/sim_mem_array.sv
hw/axi_write_engine.sv
hw/axi_read_engine.sv
hw/mmio_sink.sv
hw/sim_mem_top.sv
verification/tb_sim_mem.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_sim_mem -f sources.f

run: build
	./obj_dir/Vtb_sim_mem | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/100ps --top-module tb_sim_mem -f sources.f

clean:
	rm -rf obj_dir sim.log
